/* verilog/lane_buf_pkg.sv */
package lane_buf_pkg;

    // Sample and lane geometry.
    localparam int sample_width = 16;
    localparam int lane_count   = 3;

    // Depth in vectors. It must be a power of two for the wrap-bit pointers.
    localparam int fifo_depth   = 16;

    // Pointers carry one wrap bit above the memory index.
    localparam int addr_width   = $clog2(fifo_depth) + 1;

    // Holds 0 to fifo_depth.
    localparam int level_width  = $clog2(fifo_depth) + 1;

    localparam int drop_width   = 16; // Saturating drop counter width.

    typedef logic signed [sample_width-1:0] sample_t;

    // One vector is one sample per lane, lane 0 in the low bits.
    typedef struct packed {
        sample_t [lane_count-1:0] lane;
    } vector_t;

    typedef struct packed {
        logic                   full;
        logic                   empty;
        logic [level_width-1:0] level;
        logic [drop_width-1:0]  drop_count;
    } buf_status_t;

endpackage

/* verilog/sample_fifo.sv */
`timescale 1ns/1ns

module sample_fifo (
    input  logic                  rd_clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  lane_buf_pkg::sample_t din,
    input  logic                  rd_en,
    output lane_buf_pkg::sample_t dout,
    output logic                  full,
    output logic                  empty
);

    // Forces every bit that is not a clean one to zero.
    // Storage that was never written then reads as zero in simulation.
    function automatic lane_buf_pkg::sample_t scrub(input lane_buf_pkg::sample_t word);
        lane_buf_pkg::sample_t result;
        for (int i = 0; i < lane_buf_pkg::sample_width; i++) begin
            case (word[i])
                1'b1:    result[i] = 1'b1;
                default: result[i] = 1'b0;
            endcase
        end
        return result;
    endfunction

    lane_buf_pkg::sample_t mem [lane_buf_pkg::fifo_depth-1:0];

    logic [lane_buf_pkg::addr_width-1:0] wr_ptr;
    logic [lane_buf_pkg::addr_width-1:0] wr_ptr_next;
    logic [lane_buf_pkg::addr_width-1:0] rd_ptr;
    logic [lane_buf_pkg::addr_width-1:0] rd_ptr_next;
    logic                                wr_accept;
    logic                                rd_accept;

    // A read is only taken against the registered empty flag.
    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    assign wr_ptr_next = wr_accept ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_ptr_next = rd_accept ? rd_ptr + 1'b1 : rd_ptr;

    // Same slot, opposite lap.
    assign full = (wr_ptr[lane_buf_pkg::addr_width-2:0] == rd_ptr[lane_buf_pkg::addr_width-2:0])
               && (wr_ptr[lane_buf_pkg::addr_width-1] != rd_ptr[lane_buf_pkg::addr_width-1]);

    always_ff @(posedge rd_clk) begin
        if (wr_accept) begin
            mem[wr_ptr[lane_buf_pkg::addr_width-2:0]] <= din;
        end
    end

    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
        end
    end

    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
        end
    end

    // The current write pointer is compared, not the next one, so a vector
    // written at this edge shows as present one edge later, once dout holds it.
    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            empty <= 1'b1;
        end else begin
            empty <= (wr_ptr == rd_ptr_next);
        end
    end

    // The head is prefetched from the next read pointer on every edge.
    always_ff @(posedge rd_clk) begin
        dout <= scrub(mem[rd_ptr_next[lane_buf_pkg::addr_width-2:0]]);
    end

endmodule

/* verilog/sample_fifo_array.sv */
`timescale 1ns/1ns

module sample_fifo_array (
    input  logic                                 rd_clk,
    input  logic                                 reset,
    input  logic                                 wr_en,
    input  lane_buf_pkg::vector_t                din,
    input  logic                                 rd_en,
    output lane_buf_pkg::vector_t                dout,
    output logic                                 full,
    output logic                                 empty,
    output logic [lane_buf_pkg::level_width-1:0] level,
    output logic [lane_buf_pkg::drop_width-1:0]  drop_count
);

    logic [lane_buf_pkg::lane_count-1:0] lane_full;
    logic [lane_buf_pkg::lane_count-1:0] lane_empty;

    logic [lane_buf_pkg::addr_width-1:0]  wr_count;
    logic [lane_buf_pkg::addr_width-1:0]  wr_count_next;
    logic [lane_buf_pkg::addr_width-1:0]  rd_count;
    logic [lane_buf_pkg::addr_width-1:0]  rd_count_next;
    logic [lane_buf_pkg::level_width-1:0] level_next;
    logic                                 wr_accept;
    logic                                 rd_accept;
    logic                                 wr_drop;

    // All lanes share both strobes, so they never drift apart.
    genvar i;
    generate
        for (i = 0; i < lane_buf_pkg::lane_count; i++) begin : g_lane
            sample_fifo u_fifo (
                .rd_clk (rd_clk),
                .reset  (reset),
                .wr_en  (wr_en),
                .din    (din.lane[i]),
                .rd_en  (rd_en),
                .dout   (dout.lane[i]),
                .full   (lane_full[i]),
                .empty  (lane_empty[i])
            );
        end
    endgenerate

    // Any lane reporting full or empty blocks the whole vector.
    assign full  = |lane_full;
    assign empty = |lane_empty;

    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;
    assign wr_drop   = wr_en & full;

    assign wr_count_next = wr_accept ? wr_count + 1'b1 : wr_count;
    assign rd_count_next = rd_accept ? rd_count + 1'b1 : rd_count;

    // Modulo difference of the wrap counts gives 0 to fifo_depth.
    assign level_next = wr_count_next - rd_count_next;

    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            wr_count <= '0;
            rd_count <= '0;
        end else begin
            wr_count <= wr_count_next;
            rd_count <= rd_count_next;
        end
    end

    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            level <= '0;
        end else begin
            level <= level_next;
        end
    end

    always_ff @(posedge rd_clk or posedge reset) begin
        if (reset) begin
            drop_count <= '0;
        end else if (wr_drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1; // Sticks at all ones.
        end
    end

endmodule

/* verilog/vector_buffer_top.sv */
`timescale 1ns/1ns

module vector_buffer_top (
    input  logic                      rd_clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  lane_buf_pkg::vector_t     din,
    input  logic                      rd_en,
    output lane_buf_pkg::vector_t     dout,
    output lane_buf_pkg::buf_status_t status
);

    logic                                 buf_full;
    logic                                 buf_empty;
    logic [lane_buf_pkg::level_width-1:0] buf_level;
    logic [lane_buf_pkg::drop_width-1:0]  buf_drops;

    sample_fifo_array u_array (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .din        (din),
        .rd_en      (rd_en),
        .dout       (dout),
        .full       (buf_full),
        .empty      (buf_empty),
        .level      (buf_level),
        .drop_count (buf_drops)
    );

    // Flags and counters leave the block as one status word.
    assign status.full       = buf_full;
    assign status.empty      = buf_empty;
    assign status.level      = buf_level;
    assign status.drop_count = buf_drops;

endmodule

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic compare_vector(input string name, input lane_buf_pkg::vector_t expected,
                              input lane_buf_pkg::vector_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
endtask

// The whole status word is compared, so one line covers flags and counters.
task automatic compare_status(input string name, input lane_buf_pkg::buf_status_t expected,
                              input lane_buf_pkg::buf_status_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
endtask

task automatic note_failure(input string text);
    error_count++;
    $display("%s", text);
endtask

task automatic report_test(input string name, input int errors_before);
    $display("Test %-16s finished with %0d error(s).", name, error_count - errors_before);
endtask

`endif

/* verif/tb_vector_buffer.sv */
`timescale 1ns/1ns

module tb_vector_buffer;

    logic                      rd_clk;
    logic                      reset;
    logic                      wr_en;
    logic                      rd_en;
    lane_buf_pkg::vector_t     din;
    lane_buf_pkg::vector_t     dout;
    lane_buf_pkg::buf_status_t status;

    // Reference model of the buffer contents and counters.
    lane_buf_pkg::vector_t      model_q[$];
    logic [15:0]                exp_drops;
    logic                       last_wr; // A write was accepted at the latest edge.
    lane_buf_pkg::buf_status_t  last_exp; // Model status for what the outputs show now.
    logic [31:0]                lfsr_state;

    `include "tb_checks.svh"

    vector_buffer_top uut (
        .rd_clk (rd_clk),
        .reset  (reset),
        .wr_en  (wr_en),
        .din    (din),
        .rd_en  (rd_en),
        .dout   (dout),
        .status (status)
    );

    initial begin
        rd_clk = 1'b0;
        forever #10 rd_clk = ~rd_clk;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic lane_buf_pkg::vector_t random_vector();
        lane_buf_pkg::vector_t v;
        logic [31:0]           bits;
        for (int i = 0; i < lane_buf_pkg::lane_count; i++) begin
            bits = random_bits(16);
            v.lane[i] = bits[15:0];
        end
        return v;
    endfunction

    // Empty lags a write by one edge, so the vector stored at the latest edge
    // does not yet count as present.
    function automatic lane_buf_pkg::buf_status_t expected_status();
        lane_buf_pkg::buf_status_t s;
        int                        count;
        count = model_q.size();
        s.full = (count == lane_buf_pkg::fifo_depth);
        s.empty = ((count - int'(last_wr)) == 0);
        s.level = count[lane_buf_pkg::level_width-1:0];
        s.drop_count = exp_drops;
        return s;
    endfunction

    // One clock of traffic. Checks the state left by the previous edge at the
    // falling edge, then predicts what the next rising edge does.
    task automatic step(input logic w, input lane_buf_pkg::vector_t d, input logic r);
        lane_buf_pkg::buf_status_t exp;
        lane_buf_pkg::vector_t     head;
        logic                      wr_ok;
        logic                      rd_ok;
        @(posedge rd_clk);
        wr_en <= w;
        din   <= d;
        rd_en <= r;
        @(negedge rd_clk);
        exp = expected_status();
        last_exp = exp;
        compare_status("status", exp, status);
        wr_ok = w && !exp.full;
        rd_ok = r && !exp.empty;
        if (rd_ok) begin
            head = model_q.pop_front();
            compare_vector("dout", head, dout);
        end
        if (wr_ok) begin
            model_q.push_back(d);
        end
        if (w && exp.full && exp_drops != 16'hffff) begin
            exp_drops = exp_drops + 16'd1;
        end
        last_wr = wr_ok;
    endtask

    task automatic wait_flag(input string name, input bit pick_full, input logic want,
                             input int limit);
        int   n;
        logic seen;
        n = 0;
        seen = pick_full ? status.full : status.empty;
        while (seen !== want && n < limit) begin
            step(1'b0, '0, 1'b0);
            seen = pick_full ? status.full : status.empty;
            n++;
        end
        if (seen !== want) begin
            note_failure($sformatf("Timed out after %0d cycles waiting for %s to become %0d.",
                                   limit, name, want));
        end else begin
            compare_flag(name, pick_full ? last_exp.full : last_exp.empty, seen);
        end
    endtask

    task automatic drain_buffer(input int limit);
        int n;
        n = 0;
        while (model_q.size() > 0 && n < limit) begin
            step(1'b0, '0, 1'b1);
            n++;
        end
        if (model_q.size() > 0) begin
            note_failure($sformatf("Timed out after %0d cycles draining the buffer.", limit));
        end
        wait_flag("status.empty", 1'b0, 1'b1, 4);
    endtask

    task automatic test_reset_state();
        int                        errors_before;
        lane_buf_pkg::buf_status_t want;
        errors_before = error_count;
        @(negedge rd_clk);
        want.full = 1'b0;
        want.empty = 1'b1;
        want.level = '0;
        want.drop_count = '0;
        compare_status("status after reset", want, status);
        compare_vector("dout after reset", '0, dout);
        report_test("reset_state", errors_before);
    endtask

    task automatic test_fill_drain();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < lane_buf_pkg::fifo_depth; i++) begin
            step(1'b1, random_vector(), 1'b0);
        end
        wait_flag("status.full", 1'b1, 1'b1, 4);
        drain_buffer(lane_buf_pkg::fifo_depth + 4);
        report_test("fill_drain", errors_before);
    endtask

    task automatic test_overflow();
        int                        errors_before;
        lane_buf_pkg::buf_status_t want;
        errors_before = error_count;
        for (int i = 0; i < lane_buf_pkg::fifo_depth; i++) begin
            step(1'b1, random_vector(), 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            step(1'b1, random_vector(), 1'b0); // Refused because the buffer is full.
        end
        step(1'b0, '0, 1'b0);
        want.full = 1'b1;
        want.empty = 1'b0;
        want.level = lane_buf_pkg::fifo_depth[lane_buf_pkg::level_width-1:0];
        want.drop_count = 16'd5;
        compare_status("status after overflow", want, status);
        drain_buffer(lane_buf_pkg::fifo_depth + 4);
        report_test("overflow", errors_before);
    endtask

    task automatic test_ignored_reads();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 6; i++) begin
            step(1'b0, '0, 1'b1);
        end
        step(1'b1, random_vector(), 1'b0);
        drain_buffer(8);
        report_test("ignored_reads", errors_before);
    endtask

    task automatic test_mixed_traffic();
        int          errors_before;
        logic [31:0] w;
        logic [31:0] r;
        errors_before = error_count;
        for (int i = 0; i < 300; i++) begin
            w = random_bits(1);
            r = random_bits(1);
            step(w[0], random_vector(), r[0]);
        end
        drain_buffer(lane_buf_pkg::fifo_depth + 4);
        report_test("mixed_traffic", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        din = '0;
        lfsr_state = 32'd86842;
        exp_drops = '0;
        last_wr = 1'b0;
        last_exp = '0;
        model_q.delete();
        repeat (4) @(posedge rd_clk);
        reset <= 1'b0;

        test_reset_state();
        test_fill_drain();
        test_overflow();
        test_ignored_reads();
        test_mixed_traffic();

        $display("Tests run: 5, checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+verif
verilog/lane_buf_pkg.sv
verilog/sample_fifo.sv
verilog/sample_fifo_array.sv
verilog/vector_buffer_top.sv
verif/tb_vector_buffer.sv

/* Makefile */
# Verilator build and run for the vector buffer testbench.

VERILATOR ?= verilator
TOP       ?= tb_vector_buffer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := verif/tb_checks.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean
.DEFAULT_GOAL := help

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		echo "Simulation passed."; \
	else \
		echo "Simulation did not pass."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
